//--- verilog/video_cfg.svh
// Video path configuration
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// ======================================================================
// Pixel word widths
// ======================================================================

// One camera colour component
`define VIDEO_COMP_W 12
// Bits kept per channel in a packed RGB word
`define VIDEO_PACK_W 5
// FIFO word
`define VIDEO_WORD_W 16
// Binary and morphology pixel
`define VIDEO_BIN_W 8
// Pixel FIFO entries
`define VIDEO_FIFO_DEPTH 16
// Frame rate input, four bits per display digit
`define VIDEO_RATE_W 24

// ======================================================================
// Default VGA timing, 640x480
// ======================================================================

// Horizontal, in pixel clocks
`define VGA_H_ACTIVE 640
`define VGA_H_FRONT 16
`define VGA_H_SYNC 96
`define VGA_H_BACK 48

// Vertical, in lines
`define VGA_V_ACTIVE 480
`define VGA_V_FRONT 10
`define VGA_V_SYNC 2
`define VGA_V_BACK 33

`endif

//--- verilog/video_pkg.sv
// Video path types
`default_nettype none

`include "video_cfg.svh"

package video_pkg;

  // Camera view shown on the display
  typedef enum logic [1:0] {
    view_rgb,
    view_binary,
    view_eroded,
    view_dilated
  } view_sel_e;

  // Phase of one timing axis, in scan order
  typedef enum logic [1:0] {
    phase_active,
    phase_front,
    phase_sync,
    phase_back
  } sync_phase_e;

  // One FIFO entry
  // Packed RGB 1:5:5:5 or a zero-extended byte
  typedef logic [`VIDEO_WORD_W-1:0] pixel_word_t;

  // Active-low segment pattern, bit 0 is segment a
  typedef logic [6:0] seg_digit_t;

endpackage

`default_nettype wire

//--- verilog/view_select.sv
// Camera view selection
`default_nettype none

`include "video_cfg.svh"

module view_select (
  input  wire logic                      ccd_pixel_clk,
  input  wire logic                      rst,
  input  wire logic [5:3]                sw,
  input  wire logic                      rgb_valid,
  input  wire logic [`VIDEO_COMP_W-1:0]  rgb_red,
  input  wire logic [`VIDEO_COMP_W-1:0]  rgb_green,
  input  wire logic [`VIDEO_COMP_W-1:0]  rgb_blue,
  input  wire logic                      bin_valid,
  input  wire logic [`VIDEO_BIN_W-1:0]   bin_pixel,
  input  wire logic                      eroded_valid,
  input  wire logic [`VIDEO_BIN_W-1:0]   eroded_pixel,
  input  wire logic                      dilated_valid,
  input  wire logic [`VIDEO_BIN_W-1:0]   dilated_pixel,
  output logic                           fifo_wr_en,
  output video_pkg::pixel_word_t         fifo_wr_data,
  output video_pkg::view_sel_e           view
);

  // Zero bits above the three packed channels
  localparam int pad_w = `VIDEO_WORD_W - 3 * `VIDEO_PACK_W;

  video_pkg::view_sel_e   view_next;
  logic                   valid_next;
  video_pkg::pixel_word_t word_next;

  // Switch priority, sw[3] first
  always_comb begin
    if (sw[3]) begin
      view_next = video_pkg::view_rgb;
    end else if (sw[4]) begin
      view_next = video_pkg::view_binary;
    end else if (sw[5]) begin
      view_next = video_pkg::view_eroded;
    end else begin
      view_next = video_pkg::view_dilated;
    end
  end

  // Only the selected source's valid counts
  always_comb begin
    case (view_next)
      video_pkg::view_rgb: begin
        valid_next = rgb_valid;
        // Top bits of red, green and blue
        word_next = {{pad_w{1'b0}},
                     rgb_red[`VIDEO_COMP_W-1 -: `VIDEO_PACK_W],
                     rgb_green[`VIDEO_COMP_W-1 -: `VIDEO_PACK_W],
                     rgb_blue[`VIDEO_COMP_W-1 -: `VIDEO_PACK_W]};
      end
      video_pkg::view_binary: begin
        valid_next = bin_valid;
        word_next  = video_pkg::pixel_word_t'(bin_pixel);
      end
      video_pkg::view_eroded: begin
        valid_next = eroded_valid;
        word_next  = video_pkg::pixel_word_t'(eroded_pixel);
      end
      default: begin
        valid_next = dilated_valid;
        word_next  = video_pkg::pixel_word_t'(dilated_pixel);
      end
    endcase
  end

  // Control outputs
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      fifo_wr_en <= 1'b0;
      view       <= video_pkg::view_rgb;
    end else begin
      fifo_wr_en <= valid_next;
      view       <= view_next;
    end
  end

  // Payload word
  always_ff @(posedge ccd_pixel_clk) begin
    fifo_wr_data <= word_next;
  end

endmodule

`default_nettype wire

//--- verilog/pixel_fifo.sv
// Pixel FIFO
`default_nettype none

`include "video_cfg.svh"

module pixel_fifo #(
  parameter int depth = `VIDEO_FIFO_DEPTH
) (
  input  wire logic                    ccd_pixel_clk,
  input  wire logic                    rst,
  input  wire logic                    wr_en,
  input  wire video_pkg::pixel_word_t  wr_data,
  input  wire logic                    rd_en,
  output video_pkg::pixel_word_t       rd_data,
  output logic                         empty,
  output logic                         full,
  output logic                         overflow
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  video_pkg::pixel_word_t mem [depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_wr;
  logic             do_rd;

  assign empty = (count == '0);
  assign full  = (count == cnt_w'(depth));

  // Accepted transfers
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // Head word falls through
  assign rd_data = mem[rd_ptr];

  // Storage
  always_ff @(posedge ccd_pixel_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // ======================================================================
  // Pointers, occupancy and overflow
  // ======================================================================

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      // Write side, wraps at depth
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      // Read side
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy holds on a simultaneous push and pop
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Dropped pixel, held until reset
      if (wr_en && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/vga_timing.sv
// VGA timing generator
`default_nettype none

`include "video_cfg.svh"

module vga_timing #(
  parameter int h_active   = `VGA_H_ACTIVE,
  parameter int h_front    = `VGA_H_FRONT,
  parameter int h_sync_len = `VGA_H_SYNC,
  parameter int h_back     = `VGA_H_BACK,
  parameter int v_active   = `VGA_V_ACTIVE,
  parameter int v_front    = `VGA_V_FRONT,
  parameter int v_sync_len = `VGA_V_SYNC,
  parameter int v_back     = `VGA_V_BACK
) (
  input  wire logic ccd_pixel_clk,
  input  wire logic rst,
  output logic      h_sync,
  output logic      v_sync,
  output logic      disp_ena
);

  localparam int h_w = $clog2(h_active + h_front + h_sync_len + h_back);
  localparam int v_w = $clog2(v_active + v_front + v_sync_len + v_back);

  video_pkg::sync_phase_e h_phase;
  video_pkg::sync_phase_e v_phase;
  logic [h_w-1:0]         h_cnt;
  logic [v_w-1:0]         v_cnt;
  logic [h_w-1:0]         h_last;
  logic [v_w-1:0]         v_last;
  logic                   line_end;

  // Scan order of the phases
  function automatic video_pkg::sync_phase_e next_phase(video_pkg::sync_phase_e p);
    case (p)
      video_pkg::phase_active: return video_pkg::phase_front;
      video_pkg::phase_front:  return video_pkg::phase_sync;
      video_pkg::phase_sync:   return video_pkg::phase_back;
      default:                 return video_pkg::phase_active;
    endcase
  endfunction

  // Last count of the current phase
  always_comb begin
    case (h_phase)
      video_pkg::phase_active: h_last = h_w'(h_active - 1);
      video_pkg::phase_front:  h_last = h_w'(h_front - 1);
      video_pkg::phase_sync:   h_last = h_w'(h_sync_len - 1);
      default:                 h_last = h_w'(h_back - 1);
    endcase
    case (v_phase)
      video_pkg::phase_active: v_last = v_w'(v_active - 1);
      video_pkg::phase_front:  v_last = v_w'(v_front - 1);
      video_pkg::phase_sync:   v_last = v_w'(v_sync_len - 1);
      default:                 v_last = v_w'(v_back - 1);
    endcase
  end

  // Last cycle of the back porch closes a line
  assign line_end = (h_phase == video_pkg::phase_back) && (h_cnt == h_last);

  // ======================================================================
  // Horizontal and vertical phase FSMs
  // ======================================================================

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      h_phase <= video_pkg::phase_active;
      h_cnt   <= '0;
    end else if (h_cnt == h_last) begin
      h_phase <= next_phase(h_phase);
      h_cnt   <= '0;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // Steps once per line
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      v_phase <= video_pkg::phase_active;
      v_cnt   <= '0;
    end else if (line_end) begin
      if (v_cnt == v_last) begin
        v_phase <= next_phase(v_phase);
        v_cnt   <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end
  end

  // Registered outputs, syncs active low
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      h_sync   <= 1'b1;
      v_sync   <= 1'b1;
      disp_ena <= 1'b0;
    end else begin
      h_sync   <= (h_phase != video_pkg::phase_sync);
      v_sync   <= (v_phase != video_pkg::phase_sync);
      disp_ena <= (h_phase == video_pkg::phase_active) &&
                  (v_phase == video_pkg::phase_active);
    end
  end

endmodule

`default_nettype wire

//--- verilog/vga_color_out.sv
// VGA colour output stage
`default_nettype none

`include "video_cfg.svh"

module vga_color_out (
  input  wire logic                    ccd_pixel_clk,
  input  wire logic                    rst,
  input  wire logic                    disp_ena,
  input  wire video_pkg::view_sel_e    view,
  input  wire logic [2:0]              channel_en,
  input  wire video_pkg::pixel_word_t  fifo_rd_data,
  input  wire logic                    fifo_empty,
  output logic                         fifo_rd_en,
  output logic [7:0]                   vga_r,
  output logic [7:0]                   vga_g,
  output logic [7:0]                   vga_b,
  output logic                         vga_blank_n
);

  localparam int pw = `VIDEO_PACK_W;

  logic [2:0][pw-1:0] field;
  logic [2:0][7:0]    chan;

  // Pop one word per displayed pixel
  assign fifo_rd_en = disp_ena && !fifo_empty;

  // Packed fields, index 0 is red
  assign field = {fifo_rd_data[pw-1:0],
                  fifo_rd_data[2*pw-1:pw],
                  fifo_rd_data[3*pw-1:2*pw]};

  // Channel expansion
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      if (view != video_pkg::view_rgb) begin
        // Binary byte on every channel
        chan[i] = fifo_rd_data[7:0];
      end else if (channel_en[i]) begin
        chan[i] = {field[i], {(8 - pw){1'b0}}};
      end else begin
        chan[i] = '0;
      end
    end
  end

  // Black while blanked or starved
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      vga_r       <= '0;
      vga_g       <= '0;
      vga_b       <= '0;
      vga_blank_n <= 1'b0;
    end else begin
      vga_r       <= fifo_rd_en ? chan[0] : 8'h00;
      vga_g       <= fifo_rd_en ? chan[1] : 8'h00;
      vga_b       <= fifo_rd_en ? chan[2] : 8'h00;
      vga_blank_n <= disp_ena;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rate_display.sv
// Frame rate seven-segment display
`default_nettype none

`include "video_cfg.svh"

module rate_display (
  input  wire logic [`VIDEO_RATE_W-1:0] rate,
  output video_pkg::seg_digit_t         hex0,
  output video_pkg::seg_digit_t         hex1,
  output video_pkg::seg_digit_t         hex2,
  output video_pkg::seg_digit_t         hex3,
  output video_pkg::seg_digit_t         hex4,
  output video_pkg::seg_digit_t         hex5
);

  localparam int digits = `VIDEO_RATE_W / 4;

  video_pkg::seg_digit_t seg [digits];

  // Hex table, segments gfedcba, lit when low
  function automatic video_pkg::seg_digit_t hex_seg(logic [3:0] nib);
    case (nib)
      4'h0:    return 7'b1000000;
      4'h1:    return 7'b1111001;
      4'h2:    return 7'b0100100;
      4'h3:    return 7'b0110000;
      4'h4:    return 7'b0011001;
      4'h5:    return 7'b0010010;
      4'h6:    return 7'b0000010;
      4'h7:    return 7'b1111000;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0010000;
      4'ha:    return 7'b0001000;
      4'hb:    return 7'b0000011;
      4'hc:    return 7'b1000110;
      4'hd:    return 7'b0100001;
      4'he:    return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  // One decoder per nibble
  always_comb begin
    for (int d = 0; d < digits; d++) begin
      seg[d] = hex_seg(rate[4*d +: 4]);
    end
  end

  // Lowest nibble on hex0
  assign hex0 = seg[0];
  assign hex1 = seg[1];
  assign hex2 = seg[2];
  assign hex3 = seg[3];
  assign hex4 = seg[4];
  assign hex5 = seg[5];

endmodule

`default_nettype wire

//--- verilog/capture_display_top.sv
// Camera capture to VGA display
`default_nettype none

`include "video_cfg.svh"

module capture_display_top #(
  parameter int h_active   = `VGA_H_ACTIVE,
  parameter int h_front    = `VGA_H_FRONT,
  parameter int h_sync_len = `VGA_H_SYNC,
  parameter int h_back     = `VGA_H_BACK,
  parameter int v_active   = `VGA_V_ACTIVE,
  parameter int v_front    = `VGA_V_FRONT,
  parameter int v_sync_len = `VGA_V_SYNC,
  parameter int v_back     = `VGA_V_BACK
) (
  input  wire logic                      ccd_pixel_clk,
  input  wire logic                      rst,
  input  wire logic [5:0]                sw,
  input  wire logic                      rgb_valid,
  input  wire logic [`VIDEO_COMP_W-1:0]  rgb_red,
  input  wire logic [`VIDEO_COMP_W-1:0]  rgb_green,
  input  wire logic [`VIDEO_COMP_W-1:0]  rgb_blue,
  input  wire logic                      bin_valid,
  input  wire logic [`VIDEO_BIN_W-1:0]   bin_pixel,
  input  wire logic                      eroded_valid,
  input  wire logic [`VIDEO_BIN_W-1:0]   eroded_pixel,
  input  wire logic                      dilated_valid,
  input  wire logic [`VIDEO_BIN_W-1:0]   dilated_pixel,
  input  wire logic [`VIDEO_RATE_W-1:0]  rate,
  output logic [7:0]                     vga_r,
  output logic [7:0]                     vga_g,
  output logic [7:0]                     vga_b,
  output logic                           vga_hs,
  output logic                           vga_vs,
  output logic                           vga_blank_n,
  output logic                           fifo_overflow,
  output video_pkg::seg_digit_t          hex0,
  output video_pkg::seg_digit_t          hex1,
  output video_pkg::seg_digit_t          hex2,
  output video_pkg::seg_digit_t          hex3,
  output video_pkg::seg_digit_t          hex4,
  output video_pkg::seg_digit_t          hex5
);

  // Write side of the pixel FIFO
  logic                   fifo_wr_en;
  video_pkg::pixel_word_t fifo_wr_data;
  video_pkg::view_sel_e   view;
  // Read side
  logic                   fifo_rd_en;
  video_pkg::pixel_word_t fifo_rd_data;
  logic                   fifo_empty;
  logic                   disp_ena;

  // ======================================================================
  // Camera view into the FIFO
  // ======================================================================

  view_select i_view_select (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .sw            (sw[5:3]),
    .rgb_valid     (rgb_valid),
    .rgb_red       (rgb_red),
    .rgb_green     (rgb_green),
    .rgb_blue      (rgb_blue),
    .bin_valid     (bin_valid),
    .bin_pixel     (bin_pixel),
    .eroded_valid  (eroded_valid),
    .eroded_pixel  (eroded_pixel),
    .dilated_valid (dilated_valid),
    .dilated_pixel (dilated_pixel),
    .fifo_wr_en    (fifo_wr_en),
    .fifo_wr_data  (fifo_wr_data),
    .view          (view)
  );

  // Full only drops pixels, no back-pressure upstream
  pixel_fifo #(
    .depth (`VIDEO_FIFO_DEPTH)
  ) i_pixel_fifo (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .wr_en         (fifo_wr_en),
    .wr_data       (fifo_wr_data),
    .rd_en         (fifo_rd_en),
    .rd_data       (fifo_rd_data),
    .empty         (fifo_empty),
    .full          (),
    .overflow      (fifo_overflow)
  );

  // ======================================================================
  // Display side
  // ======================================================================

  vga_timing #(
    .h_active   (h_active),
    .h_front    (h_front),
    .h_sync_len (h_sync_len),
    .h_back     (h_back),
    .v_active   (v_active),
    .v_front    (v_front),
    .v_sync_len (v_sync_len),
    .v_back     (v_back)
  ) i_vga_timing (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .h_sync        (vga_hs),
    .v_sync        (vga_vs),
    .disp_ena      (disp_ena)
  );

  // Low switches gate the RGB channels
  vga_color_out i_vga_color_out (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .disp_ena      (disp_ena),
    .view          (view),
    .channel_en    (sw[2:0]),
    .fifo_rd_data  (fifo_rd_data),
    .fifo_empty    (fifo_empty),
    .fifo_rd_en    (fifo_rd_en),
    .vga_r         (vga_r),
    .vga_g         (vga_g),
    .vga_b         (vga_b),
    .vga_blank_n   (vga_blank_n)
  );

  // Frame rate digits
  rate_display i_rate_display (
    .rate (rate),
    .hex0 (hex0),
    .hex1 (hex1),
    .hex2 (hex2),
    .hex3 (hex3),
    .hex4 (hex4),
    .hex5 (hex5)
  );

endmodule

`default_nettype wire

//--- sim/capture_display_assert.sv
// FIFO and sync assertions
`default_nettype none

module capture_display_assert (
  input wire logic ccd_pixel_clk,
  input wire logic rst,
  input wire logic full,
  input wire logic empty,
  input wire logic overflow,
  input wire logic h_sync,
  input wire logic disp_ena
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failures seen, read by the testbench
  int fail_count = 0;

  // FIFO cannot be full and empty at once
  full_empty_excl: assert property (@(posedge ccd_pixel_clk) disable iff (rst)
    !(full && empty))
    else begin
      $error("FIFO full and empty at the same time");
      fail_count++;
    end

  // Sticky overflow, only rst clears it
  overflow_sticky: assert property (@(posedge ccd_pixel_clk)
    (!$past(rst) && $past(overflow)) |-> overflow)
    else begin
      $error("FIFO overflow fell without reset");
      fail_count++;
    end

  // No displayed pixel inside the horizontal sync pulse
  ena_outside_sync: assert property (@(posedge ccd_pixel_clk) disable iff (rst)
    disp_ena |-> h_sync)
    else begin
      $error("Display enabled during horizontal sync");
      fail_count++;
    end

endmodule

// ======================================================================
// Bindings, unused inputs tied to their idle levels
// ======================================================================

bind pixel_fifo capture_display_assert i_fifo_assert (
  .ccd_pixel_clk (ccd_pixel_clk),
  .rst           (rst),
  .full          (full),
  .empty         (empty),
  .overflow      (overflow),
  .h_sync        (1'b1),
  .disp_ena      (1'b0)
);

bind vga_timing capture_display_assert i_timing_assert (
  .ccd_pixel_clk (ccd_pixel_clk),
  .rst           (rst),
  .full          (1'b0),
  .empty         (1'b1),
  .overflow      (1'b0),
  .h_sync        (h_sync),
  .disp_ena      (disp_ena)
);

`default_nettype wire

//--- sim/tb_capture_display.sv
// Capture display testbench
`default_nettype none

`include "video_cfg.svh"

module tb_capture_display;
  timeunit 1ns;
  timeprecision 100ps;

  // Small VGA timing
  localparam int h_act = 8;
  localparam int h_fp = 2;
  localparam int h_sy = 2;
  localparam int h_bp = 2;
  localparam int v_act = 4;
  localparam int v_fp = 1;
  localparam int v_sy = 1;
  localparam int v_bp = 1;
  localparam int v_total = v_act + v_fp + v_sy + v_bp;
  localparam int frame_len = (h_act + h_fp + h_sy + h_bp) * v_total;
  localparam int table_len = 9;
  localparam int pixels_per_entry = 16;
  // One pixel every 4 clocks stays under the display rate
  localparam int pixel_gap = 4;
  localparam int cycle_limit = 2 * table_len * frame_len;
  localparam int cw = `VIDEO_COMP_W;
  localparam int pw = `VIDEO_PACK_W;

  // Valid mask bits: 0 rgb, 1 binary, 2 eroded, 3 dilated
  typedef struct packed {
    logic [5:3] sel;
    logic [2:0] chan_en;
    logic [3:0] valid_mask;
  } stim_t;

  typedef struct packed {
    video_pkg::view_sel_e view;
    logic [7:0]           r;
    logic [7:0]           g;
    logic [7:0]           b;
  } exp_pixel_t;

  logic                     ccd_pixel_clk;
  logic                     rst;
  logic [5:0]               sw;
  logic                     rgb_valid;
  logic [cw-1:0]            rgb_red;
  logic [cw-1:0]            rgb_green;
  logic [cw-1:0]            rgb_blue;
  logic                     bin_valid;
  logic [`VIDEO_BIN_W-1:0]  bin_pixel;
  logic                     eroded_valid;
  logic [`VIDEO_BIN_W-1:0]  eroded_pixel;
  logic                     dilated_valid;
  logic [`VIDEO_BIN_W-1:0]  dilated_pixel;
  logic [`VIDEO_RATE_W-1:0] rate;
  logic [7:0]               vga_r;
  logic [7:0]               vga_g;
  logic [7:0]               vga_b;
  logic                     vga_hs;
  logic                     vga_vs;
  logic                     vga_blank_n;
  logic                     fifo_overflow;
  video_pkg::seg_digit_t    hex0;
  video_pkg::seg_digit_t    hex1;
  video_pkg::seg_digit_t    hex2;
  video_pkg::seg_digit_t    hex3;
  video_pkg::seg_digit_t    hex4;
  video_pkg::seg_digit_t    hex5;

  stim_t      stim_table [table_len];
  exp_pixel_t exp_q [$];
  int         ready_q [$];
  logic [15:0] lfsr_state = 16'd50;
  int cycle_cnt = 0;
  int colour_errors = 0;
  int seg_errors = 0;
  int count_errors = 0;
  int level_errors = 0;
  // Frame statistics
  logic prev_hs = 1'b1;
  logic prev_vs = 1'b1;
  int   hs_low_len = 0;
  int   hs_pulses = 0;
  int   active_cnt = 0;
  int   frames = 0;
  bit   frame_started = 1'b0;

  capture_display_top #(
    .h_active (h_act), .h_front (h_fp), .h_sync_len (h_sy), .h_back (h_bp),
    .v_active (v_act), .v_front (v_fp), .v_sync_len (v_sy), .v_back (v_bp)
  ) i_capture_display_top (
    .ccd_pixel_clk (ccd_pixel_clk), .rst (rst), .sw (sw),
    .rgb_valid (rgb_valid), .rgb_red (rgb_red), .rgb_green (rgb_green),
    .rgb_blue (rgb_blue), .bin_valid (bin_valid), .bin_pixel (bin_pixel),
    .eroded_valid (eroded_valid), .eroded_pixel (eroded_pixel),
    .dilated_valid (dilated_valid), .dilated_pixel (dilated_pixel),
    .rate (rate), .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b),
    .vga_hs (vga_hs), .vga_vs (vga_vs), .vga_blank_n (vga_blank_n),
    .fifo_overflow (fifo_overflow), .hex0 (hex0), .hex1 (hex1),
    .hex2 (hex2), .hex3 (hex3), .hex4 (hex4), .hex5 (hex5)
  );

  initial begin
    ccd_pixel_clk = 1'b0;
    forever #2 ccd_pixel_clk = ~ccd_pixel_clk;
  end

  // ======================================================================
  // Stimulus source and reference model
  // ======================================================================

  // 16-bit Galois LFSR, right shift
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hb400;
    end
    return n;
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Switch priority, sw[3] highest
  function automatic video_pkg::view_sel_e decode_view(input logic [5:3] sel);
    if (sel[3]) return video_pkg::view_rgb;
    if (sel[4]) return video_pkg::view_binary;
    if (sel[5]) return video_pkg::view_eroded;
    return video_pkg::view_dilated;
  endfunction

  // Lit segments gfedcba, inverted for the active-low display
  function automatic video_pkg::seg_digit_t seg_expect(input logic [3:0] n);
    logic [6:0] lit;
    case (n)
      4'h0: lit = 7'h3f;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5b;
      4'h3: lit = 7'h4f;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6d;
      4'h6: lit = 7'h7d;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7f;
      4'h9: lit = 7'h6f;
      4'ha: lit = 7'h77;
      4'hb: lit = 7'h7c;
      4'hc: lit = 7'h39;
      4'hd: lit = 7'h5e;
      4'he: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  // Random pixel on every source, expected colour queued if accepted
  task automatic drive_pixel(input stim_t st);
    logic [31:0]          bits;
    video_pkg::view_sel_e v;
    logic                 sel_valid;
    exp_pixel_t           e;
    take_bits(cw, bits);
    rgb_red = bits[cw-1:0];
    take_bits(cw, bits);
    rgb_green = bits[cw-1:0];
    take_bits(cw, bits);
    rgb_blue = bits[cw-1:0];
    take_bits(8, bits);
    bin_pixel = bits[7:0];
    take_bits(8, bits);
    eroded_pixel = bits[7:0];
    take_bits(8, bits);
    dilated_pixel = bits[7:0];
    rgb_valid = st.valid_mask[0];
    bin_valid = st.valid_mask[1];
    eroded_valid = st.valid_mask[2];
    dilated_valid = st.valid_mask[3];
    v = decode_view(st.sel);
    e.view = v;
    case (v)
      video_pkg::view_rgb: begin
        sel_valid = rgb_valid;
        e.r = st.chan_en[0] ? {rgb_red[cw-1 -: pw], 3'b000} : 8'h00;
        e.g = st.chan_en[1] ? {rgb_green[cw-1 -: pw], 3'b000} : 8'h00;
        e.b = st.chan_en[2] ? {rgb_blue[cw-1 -: pw], 3'b000} : 8'h00;
      end
      video_pkg::view_binary: begin
        sel_valid = bin_valid;
        e.r = bin_pixel;
        e.g = bin_pixel;
        e.b = bin_pixel;
      end
      video_pkg::view_eroded: begin
        sel_valid = eroded_valid;
        e.r = eroded_pixel;
        e.g = eroded_pixel;
        e.b = eroded_pixel;
      end
      default: begin
        sel_valid = dilated_valid;
        e.r = dilated_pixel;
        e.g = dilated_pixel;
        e.b = dilated_pixel;
      end
    endcase
    // Two clocks into the FIFO, one more to the colour register
    if (sel_valid) begin
      exp_q.push_back(e);
      ready_q.push_back(cycle_cnt + 3);
    end
  endtask

  task automatic clear_valids();
    rgb_valid = 1'b0;
    bin_valid = 1'b0;
    eroded_valid = 1'b0;
    dilated_valid = 1'b0;
  endtask

  // ======================================================================
  // Compare tasks
  // ======================================================================

  task automatic check_colour(input logic [7:0] got_r, input logic [7:0] got_g,
                              input logic [7:0] got_b, input logic [7:0] exp_r,
                              input logic [7:0] exp_g, input logic [7:0] exp_b,
                              input video_pkg::view_sel_e view);
    if ({got_r, got_g, got_b} !== {exp_r, exp_g, exp_b}) begin
      colour_errors++;
      $display("[FAIL] %0t: colour in %s got %h %h %h, expected %h %h %h", $time,
               view.name(), got_r, got_g, got_b, exp_r, exp_g, exp_b);
    end
  endtask

  task automatic check_seg(input video_pkg::seg_digit_t got,
                           input video_pkg::seg_digit_t exp, input int digit);
    if (got !== exp) begin
      seg_errors++;
      $display("[FAIL] %0t: hex%0d got %b, expected %b", $time, digit, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      count_errors++;
      $display("[FAIL] %0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      level_errors++;
      $display("[FAIL] %0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Cycle count and run limit
  always @(posedge ccd_pixel_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run exceeded %0d clock cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  // Output monitor, outputs stable at the falling edge
  always @(negedge ccd_pixel_clk) begin
    exp_pixel_t e;
    if (!rst) begin
      if (vga_blank_n) begin
        active_cnt++;
        if (exp_q.size() > 0 && ready_q[0] <= cycle_cnt) begin
          e = exp_q.pop_front();
          void'(ready_q.pop_front());
          check_colour(vga_r, vga_g, vga_b, e.r, e.g, e.b, e.view);
        end else begin
          // Starved display shows black
          check_colour(vga_r, vga_g, vga_b, 8'h00, 8'h00, 8'h00, decode_view(sw[5:3]));
        end
      end else begin
        check_colour(vga_r, vga_g, vga_b, 8'h00, 8'h00, 8'h00, decode_view(sw[5:3]));
      end
      // Horizontal sync pulses
      if (!vga_hs) hs_low_len++;
      if (!vga_hs && prev_hs) hs_pulses++;
      if (vga_hs && !prev_hs) begin
        check_count("hsync pulse length", hs_low_len, h_sy);
        hs_low_len = 0;
      end
      // Frame boundary at the vsync fall
      if (!vga_vs && prev_vs) begin
        if (frame_started) begin
          check_count("hsync pulses per frame", hs_pulses, v_total);
          check_count("displayed pixels per frame", active_cnt, h_act * v_act);
          frames++;
        end
        frame_started = 1'b1;
        hs_pulses = 0;
        active_cnt = 0;
      end
      prev_hs = vga_hs;
      prev_vs = vga_vs;
    end
  end

  // ======================================================================
  // Main sequence
  // ======================================================================

  initial begin
    logic [31:0] bits;
    stim_t       st;
    int          assert_errors;
    int          total;
    rst = 1'b1;
    sw = '0;
    rate = '0;
    rgb_red = '0;
    rgb_green = '0;
    rgb_blue = '0;
    bin_pixel = '0;
    eroded_pixel = '0;
    dilated_pixel = '0;
    clear_valids();
    // sw[5:3], channel enables, valid mask
    stim_table[0] = {3'b001, 3'b111, 4'b1111};
    stim_table[1] = {3'b001, 3'b101, 4'b0001};
    stim_table[2] = {3'b001, 3'b010, 4'b1110};
    stim_table[3] = {3'b010, 3'b000, 4'b1111};
    stim_table[4] = {3'b110, 3'b111, 4'b0010};
    stim_table[5] = {3'b100, 3'b011, 4'b1101};
    stim_table[6] = {3'b000, 3'b100, 4'b1000};
    stim_table[7] = {3'b000, 3'b111, 4'b0111};
    stim_table[8] = {3'b011, 3'b010, 4'b0011};

    repeat (4) @(posedge ccd_pixel_clk);
    @(negedge ccd_pixel_clk);
    // Idle outputs while in reset
    check_level("vga_blank_n in reset", vga_blank_n, 1'b0);
    check_colour(vga_r, vga_g, vga_b, 8'h00, 8'h00, 8'h00, video_pkg::view_rgb);
    check_level("vga_hs in reset", vga_hs, 1'b1);
    check_level("vga_vs in reset", vga_vs, 1'b1);
    check_level("fifo_overflow in reset", fifo_overflow, 1'b0);
    rst = 1'b0;

    // Frame rate digits
    for (int k = 0; k < 8; k++) begin
      @(negedge ccd_pixel_clk);
      take_bits(`VIDEO_RATE_W, bits);
      rate = bits[`VIDEO_RATE_W-1:0];
      @(posedge ccd_pixel_clk);
      check_seg(hex0, seg_expect(rate[3:0]), 0);
      check_seg(hex1, seg_expect(rate[7:4]), 1);
      check_seg(hex2, seg_expect(rate[11:8]), 2);
      check_seg(hex3, seg_expect(rate[15:12]), 3);
      check_seg(hex4, seg_expect(rate[19:16]), 4);
      check_seg(hex5, seg_expect(rate[23:20]), 5);
    end

    // Switches stay fixed until the entry has drained
    for (int e = 0; e < table_len; e++) begin
      st = stim_table[e];
      @(negedge ccd_pixel_clk);
      sw = {st.sel, st.chan_en};
      repeat (2) @(negedge ccd_pixel_clk);
      for (int p = 0; p < pixels_per_entry; p++) begin
        drive_pixel(st);
        @(negedge ccd_pixel_clk);
        clear_valids();
        repeat (pixel_gap - 1) @(negedge ccd_pixel_clk);
      end
      while (exp_q.size() != 0) @(negedge ccd_pixel_clk);
    end

    // One idle frame of black output
    repeat (frame_len) @(negedge ccd_pixel_clk);
    check_level("fifo_overflow at end", fifo_overflow, 1'b0);
    check_level("complete frames observed", frames > 1, 1'b1);
    // Let the monitor finish its last falling-edge sample
    @(posedge ccd_pixel_clk);

    assert_errors = i_capture_display_top.i_pixel_fifo.i_fifo_assert.fail_count +
                    i_capture_display_top.i_vga_timing.i_timing_assert.fail_count;
    total = colour_errors + seg_errors + count_errors + level_errors + assert_errors;
    $display("Errors: colour %0d, segment %0d, count %0d, level %0d, assertion %0d, total %0d",
             colour_errors, seg_errors, count_errors, level_errors, assert_errors, total);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+verilog
verilog/video_pkg.sv
verilog/view_select.sv
verilog/pixel_fifo.sv
verilog/vga_timing.sv
verilog/vga_color_out.sv
verilog/rate_display.sv
verilog/capture_display_top.sv
sim/capture_display_assert.sv
sim/tb_capture_display.sv
